//--- rtl/adc_format_pkg.sv
// ADC sample format
// Word width, default channel count and the training word
`default_nettype none

package adc_format_pkg;

	// Bits per serial sample, MSB first on the wire
	localparam int WORD_BITS = 12;

	// Channels carried by one ADC segment
	localparam int DEF_CHANNELS = 8;

	typedef logic [WORD_BITS-1:0] sample_t;

	// Training word sent by the ADC during alignment
	localparam sample_t TRAIN_PATTERN = 12'h463;

endpackage

`default_nettype wire

//--- rtl/align_pkg.sv
// Lane alignment definitions
// FSM state type and the timing constants of the alignment sequence
`default_nettype none

package align_pkg;

	typedef enum logic [2:0] {
		RESET,
		SETTLE,
		CHECK,
		SLIP,
		ALIGNED
	} align_state_t;

	// Words dropped after a reset or a slip
	localparam int SETTLE_WORDS = 2;

	// Back-to-back training words before the lane counts as aligned
	localparam int MATCH_COUNT = 4;

	// Length of the lane reset pulse in clocks
	localparam int RESET_STRETCH = 4;

endpackage

`default_nettype wire

//--- rtl/lane_status_if.sv
// Lane status bundle
// Carries one lane's sample words and alignment status to the collector
`timescale 1ns/1ps
`default_nettype none

interface lane_status_if #(
	parameter int CHANNELS = adc_format_pkg::DEF_CHANNELS
);
	import adc_format_pkg::*;

	// Channel 0 in the lowest word
	sample_t [CHANNELS-1:0] samples;
	// One-cycle strobe, no handshake
	logic sample_valid;
	logic aligned;
	logic restart;

	modport lane (
		output samples,
		output sample_valid,
		output aligned,
		output restart
	);

	modport collector (
		input samples,
		input sample_valid,
		input aligned,
		input restart
	);

endinterface

`default_nettype wire

//--- rtl/resync_ctrl.sv
// Resync controller
// Turns system reset and resync edges into a stretched lane reset
`timescale 1ns/1ps
`default_nettype none

module resync_ctrl (
	input  logic CLK20,
	input  logic SYS_RST,
	input  logic resync,
	output logic lane_rst
);
	import align_pkg::*;

	localparam int CNT_W = $clog2(RESET_STRETCH + 1);

	logic             resync_q;
	logic             resync_rise;
	logic [CNT_W-1:0] stretch_cnt;

	// Rising edge of the request, acted on at the next clock
	assign resync_rise = resync & ~resync_q;

	always_ff @(posedge CLK20 or posedge SYS_RST) begin
		if (SYS_RST) begin
			resync_q <= 1'b0;
		end else begin
			resync_q <= resync;
		end
	end

	// Counter reloads on every request, so back-to-back requests extend the pulse
	always_ff @(posedge CLK20 or posedge SYS_RST) begin
		if (SYS_RST) begin
			stretch_cnt <= CNT_W'(RESET_STRETCH);
		end else if (resync_rise) begin
			stretch_cnt <= CNT_W'(RESET_STRETCH);
		end else if (stretch_cnt != '0) begin
			stretch_cnt <= stretch_cnt - 1'b1;
		end
	end

	assign lane_rst = (stretch_cnt != '0);

endmodule

`default_nettype wire

//--- rtl/channel_deser.sv
// Channel deserializer
// Shifts one serial bit per clock and frames 12-bit words, with bit slip
`timescale 1ns/1ps
`default_nettype none

module channel_deser (
	input  logic                    CLK20,
	input  logic                    SYS_RST,
	input  logic                    lane_rst,
	input  logic                    serial_bit,
	input  logic                    bit_slip,
	output adc_format_pkg::sample_t word,
	output logic                    word_valid
);
	import adc_format_pkg::*;

	localparam int CNT_W = $clog2(WORD_BITS);

	sample_t          shift_reg;
	sample_t          shift_next;
	logic [CNT_W-1:0] frame_cnt;
	logic             frame_wrap;

	// MSB arrives first, so new bits enter at the bottom
	assign shift_next = {shift_reg[WORD_BITS-2:0], serial_bit};
	assign frame_wrap = (frame_cnt == CNT_W'(WORD_BITS - 1)) && !bit_slip;

	always_ff @(posedge CLK20) begin
		shift_reg <= shift_next;
		if (frame_wrap) begin
			word <= shift_next;
		end
	end

	//////////////////////////////////////////////////
	// Frame counter
	//////////////////////////////////////////////////

	// A slip holds the count for one clock and pushes the boundary one bit later
	always_ff @(posedge CLK20 or posedge SYS_RST) begin
		if (SYS_RST) begin
			frame_cnt  <= '0;
			word_valid <= 1'b0;
		end else if (lane_rst) begin
			frame_cnt  <= '0;
			word_valid <= 1'b0;
		end else begin
			word_valid <= frame_wrap;
			if (bit_slip) begin
				frame_cnt <= frame_cnt;
			end else if (frame_wrap) begin
				frame_cnt <= '0;
			end else begin
				frame_cnt <= frame_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/lane_align_fsm.sv
// Lane alignment FSM
// Slips the word boundary until channel 0 carries the training word
`timescale 1ns/1ps
`default_nettype none

module lane_align_fsm (
	input  logic                    CLK20,
	input  logic                    SYS_RST,
	input  logic                    lane_rst,
	input  adc_format_pkg::sample_t word,
	input  logic                    word_valid,
	output logic                    bit_slip,
	output logic                    aligned,
	output logic                    restart
);
	import adc_format_pkg::*;
	import align_pkg::*;

	localparam int SET_W   = $clog2(SETTLE_WORDS + 1);
	localparam int MATCH_W = $clog2(MATCH_COUNT + 1);

	align_state_t       state;
	logic [SET_W-1:0]   settle_cnt;
	logic [MATCH_W-1:0] match_cnt;
	logic               word_match;

	assign word_match = (word == TRAIN_PATTERN);

	always_ff @(posedge CLK20 or posedge SYS_RST) begin
		if (SYS_RST) begin
			state      <= RESET;
			settle_cnt <= '0;
			match_cnt  <= '0;
			restart    <= 1'b0;
		end else if (lane_rst) begin
			state      <= RESET;
			settle_cnt <= '0;
			match_cnt  <= '0;
			restart    <= 1'b0;
		end else begin
			restart <= 1'b0;
			case (state)
				RESET: begin
					settle_cnt <= '0;
					match_cnt  <= '0;
					state      <= SETTLE;
				end
				// Drop the words framed around a boundary change
				SETTLE: begin
					if (word_valid) begin
						if (settle_cnt == SET_W'(SETTLE_WORDS - 1)) begin
							settle_cnt <= '0;
							state      <= CHECK;
						end else begin
							settle_cnt <= settle_cnt + 1'b1;
						end
					end
				end
				CHECK: begin
					if (word_valid && word_match) begin
						if (match_cnt == MATCH_W'(MATCH_COUNT - 1)) begin
							state   <= ALIGNED;
							restart <= 1'b1;
						end else begin
							match_cnt <= match_cnt + 1'b1;
						end
					end else if (word_valid) begin
						match_cnt <= '0;
						state     <= SLIP;
					end
				end
				SLIP:    state <= SETTLE;
				// Held until the next lane reset
				ALIGNED: state <= ALIGNED;
				default: state <= RESET;
			endcase
		end
	end

	assign bit_slip = (state == SLIP);
	assign aligned  = (state == ALIGNED);

endmodule

`default_nettype wire

//--- rtl/adc_lane.sv
// ADC lane
// Deserializes every channel of one segment and aligns on channel 0
`timescale 1ns/1ps
`default_nettype none

module adc_lane #(
	parameter int CHANNELS = adc_format_pkg::DEF_CHANNELS
) (
	input  logic                CLK20,
	input  logic                SYS_RST,
	input  logic                lane_rst,
	input  logic [CHANNELS-1:0] serial_in,
	lane_status_if.lane         status
);
	import adc_format_pkg::*;

	sample_t [CHANNELS-1:0] ch_word;
	logic    [CHANNELS-1:0] ch_valid;
	logic                   lane_slip;
	logic                   lane_aligned;
	logic                   lane_restart;

	// One slip for the whole lane keeps every channel on the same boundary
	for (genvar ch = 0; ch < CHANNELS; ch++) begin : g_chan
		channel_deser i_deser (
			.CLK20      (CLK20),
			.SYS_RST    (SYS_RST),
			.lane_rst   (lane_rst),
			.serial_bit (serial_in[ch]),
			.bit_slip   (lane_slip),
			.word       (ch_word[ch]),
			.word_valid (ch_valid[ch])
		);
	end

	lane_align_fsm i_align (
		.CLK20      (CLK20),
		.SYS_RST    (SYS_RST),
		.lane_rst   (lane_rst),
		.word       (ch_word[0]),
		.word_valid (ch_valid[0]),
		.bit_slip   (lane_slip),
		.aligned    (lane_aligned),
		.restart    (lane_restart)
	);

	assign status.samples      = ch_word;
	assign status.sample_valid = &ch_valid;
	assign status.aligned      = lane_aligned;
	assign status.restart      = lane_restart;

endmodule

`default_nettype wire

//--- rtl/daq_collector.sv
// DAQ collector
// Registers all lane samples into flat outputs and merges lane status
`timescale 1ns/1ps
`default_nettype none

module daq_collector #(
	parameter int NUM_LANES = 4,
	parameter int CHANNELS  = adc_format_pkg::DEF_CHANNELS
) (
	input  logic                  CLK20,
	input  logic                  SYS_RST,
	lane_status_if.collector      lanes [NUM_LANES],
	output logic [NUM_LANES*CHANNELS*adc_format_pkg::WORD_BITS-1:0] samples,
	output logic [NUM_LANES-1:0]  sample_valid,
	output logic [NUM_LANES-1:0]  restart,
	output logic                  aligned,
	output logic                  align_good
);
	import adc_format_pkg::*;

	localparam int LANE_W = CHANNELS * WORD_BITS;

	wire [LANE_W-1:0]    lane_words [NUM_LANES];
	wire [NUM_LANES-1:0] lane_valid;
	wire [NUM_LANES-1:0] lane_aligned;
	wire [NUM_LANES-1:0] lane_restart;

	for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
		assign lane_words[l]   = lanes[l].samples;
		assign lane_valid[l]   = lanes[l].sample_valid;
		assign lane_aligned[l] = lanes[l].aligned;
		assign lane_restart[l] = lanes[l].restart;
	end

	// Lane 0 lowest, channel 0 lowest within a lane
	always_ff @(posedge CLK20) begin
		for (int l = 0; l < NUM_LANES; l++) begin
			if (lane_valid[l]) begin
				samples[l*LANE_W +: LANE_W] <= lane_words[l];
			end
		end
	end

	always_ff @(posedge CLK20 or posedge SYS_RST) begin
		if (SYS_RST) begin
			sample_valid <= '0;
			restart      <= '0;
			aligned      <= 1'b0;
			align_good   <= 1'b0;
		end else begin
			sample_valid <= lane_valid;
			restart      <= lane_restart;
			aligned      <= &lane_aligned;
			// Training check on lane 0 channel 0
			if (lane_valid[0]) begin
				align_good <= (lane_words[0][WORD_BITS-1:0] == TRAIN_PATTERN);
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/adc_deser_top.sv
// Serial ADC capture front end
// Resync control, one deserializing lane per ADC segment and the collector
`timescale 1ns/1ps
`default_nettype none

module adc_deser_top #(
	parameter int NUM_LANES = 4,
	parameter int CHANNELS  = adc_format_pkg::DEF_CHANNELS
) (
	input  logic                           CLK20,
	input  logic                           SYS_RST,
	input  logic                           resync,
	input  logic [NUM_LANES*CHANNELS-1:0]  serial_in,
	output logic [NUM_LANES*CHANNELS*adc_format_pkg::WORD_BITS-1:0] samples,
	output logic [NUM_LANES-1:0]           sample_valid,
	output logic [NUM_LANES-1:0]           restart,
	output logic                           aligned,
	output logic                           align_good
);

	logic lane_rst;

	lane_status_if #(.CHANNELS(CHANNELS)) lane_bus [NUM_LANES] ();

	resync_ctrl i_resync (
		.CLK20    (CLK20),
		.SYS_RST  (SYS_RST),
		.resync   (resync),
		.lane_rst (lane_rst)
	);

	//////////////////////////////////////////////////
	// ADC lanes
	//////////////////////////////////////////////////

	for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
		adc_lane #(
			.CHANNELS (CHANNELS)
		) i_lane (
			.CLK20     (CLK20),
			.SYS_RST   (SYS_RST),
			.lane_rst  (lane_rst),
			.serial_in (serial_in[l*CHANNELS +: CHANNELS]),
			.status    (lane_bus[l])
		);
	end

	daq_collector #(
		.NUM_LANES (NUM_LANES),
		.CHANNELS  (CHANNELS)
	) i_collector (
		.CLK20        (CLK20),
		.SYS_RST      (SYS_RST),
		.lanes        (lane_bus),
		.samples      (samples),
		.sample_valid (sample_valid),
		.restart      (restart),
		.aligned      (aligned),
		.align_good   (align_good)
	);

endmodule

`default_nettype wire

//--- testbench/adc_serial_model.sv
// ADC serial stream model
// Sends training or per-channel data words MSB first, with a bit offset per lane
`timescale 1ns/1ps
`default_nettype none

module adc_serial_model #(
	parameter int NUM_LANES = 4,
	parameter int CHANNELS  = adc_format_pkg::DEF_CHANNELS
) (
	input  logic                          CLK20,
	input  logic                          SYS_RST,
	input  logic                          send_data,
	input  logic [NUM_LANES*4-1:0]        offsets,
	output logic [NUM_LANES*CHANNELS-1:0] serial_out
);
	import adc_format_pkg::*;

	int bit_cnt;

	// Lane number in bits 7:4, channel number in bits 3:0
	function automatic sample_t data_word(input int lane, input int ch);
		return sample_t'(12'hA00 + 16 * lane + ch);
	endfunction

	// Offset shifts where the lane's words start within the bit count
	function automatic logic next_bit(input int lane, input int ch);
		sample_t w;
		int      pos;
		w   = send_data ? data_word(lane, ch) : TRAIN_PATTERN;
		pos = (bit_cnt + int'(offsets[lane*4 +: 4])) % WORD_BITS;
		return w[WORD_BITS-1-pos];
	endfunction

	always @(negedge CLK20 or posedge SYS_RST) begin
		if (SYS_RST) begin
			bit_cnt    <= 0;
			serial_out <= '0;
		end else begin
			bit_cnt <= (bit_cnt == WORD_BITS - 1) ? 0 : bit_cnt + 1;
			for (int l = 0; l < NUM_LANES; l++) begin
				for (int c = 0; c < CHANNELS; c++) begin
					serial_out[l*CHANNELS + c] <= next_bit(l, c);
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_adc_deser.sv
// Testbench for the serial ADC capture front end
// Aligns every lane on training, checks data words, then resyncs
`timescale 1ns/1ps
`default_nettype none

module tb_adc_deser;
	import adc_format_pkg::*;

	localparam int NUM_LANES   = 4;
	localparam int CHANNELS    = DEF_CHANNELS;
	localparam int ALIGN_LIMIT = 3000;
	localparam int WORD_LIMIT  = 40;

	localparam logic [1:0] MODE_IDLE  = 2'd0;
	localparam logic [1:0] MODE_TRAIN = 2'd1;
	localparam logic [1:0] MODE_DATA  = 2'd2;

	logic                                    CLK20;
	logic                                    SYS_RST;
	logic                                    resync;
	logic                                    send_data;
	logic [NUM_LANES*4-1:0]                  offsets;
	logic [NUM_LANES*CHANNELS-1:0]           serial_in;
	logic [NUM_LANES*CHANNELS*WORD_BITS-1:0] samples;
	logic [NUM_LANES-1:0]                    sample_valid;
	logic [NUM_LANES-1:0]                    restart;
	logic                                    aligned;
	logic                                    align_good;

	logic [1:0] check_mode;
	int         restart_cnt [NUM_LANES];
	int         error_count;
	int         tests_run;
	int         tests_failed;
	bit         timed_out;

	adc_serial_model #(
		.NUM_LANES (NUM_LANES),
		.CHANNELS  (CHANNELS)
	) i_model (
		.CLK20      (CLK20),
		.SYS_RST    (SYS_RST),
		.send_data  (send_data),
		.offsets    (offsets),
		.serial_out (serial_in)
	);

	adc_deser_top #(
		.NUM_LANES (NUM_LANES),
		.CHANNELS  (CHANNELS)
	) i_dut (
		.CLK20        (CLK20),
		.SYS_RST      (SYS_RST),
		.resync       (resync),
		.serial_in    (serial_in),
		.samples      (samples),
		.sample_valid (sample_valid),
		.restart      (restart),
		.aligned      (aligned),
		.align_good   (align_good)
	);

	initial begin
		CLK20 = 1'b0;
		forever #10 CLK20 = ~CLK20;
	end

	// Restart pulses per lane, counted on the clock after they show
	always @(posedge CLK20) begin
		for (int l = 0; l < NUM_LANES; l++) begin
			if (SYS_RST) begin
				restart_cnt[l] <= 0;
			end else if (restart[l]) begin
				restart_cnt[l] <= restart_cnt[l] + 1;
			end
		end
	end

	task automatic report_error(input string msg);
		error_count++;
		$display("ERROR %0t ns: %s", $time, msg);
	endtask

	//////////////////////////////////////////////////
	// Word checks
	//////////////////////////////////////////////////

	for (genvar l = 0; l < NUM_LANES; l++) begin : g_chk_lane
		for (genvar c = 0; c < CHANNELS; c++) begin : g_chk_ch
			localparam int      IDX       = (l * CHANNELS + c) * WORD_BITS;
			localparam sample_t DATA_WORD = sample_t'(12'hA00 + 16 * l + c);

			assert property (@(posedge CLK20) disable iff (SYS_RST)
				(check_mode == MODE_TRAIN && sample_valid[l])
					|-> samples[IDX +: WORD_BITS] == TRAIN_PATTERN)
			else report_error($sformatf("lane %0d ch %0d got %h, expected training %h",
				l, c, $sampled(samples[IDX +: WORD_BITS]), TRAIN_PATTERN));

			assert property (@(posedge CLK20) disable iff (SYS_RST)
				(check_mode == MODE_DATA && sample_valid[l])
					|-> samples[IDX +: WORD_BITS] == DATA_WORD)
			else report_error($sformatf("lane %0d ch %0d got %h, expected data %h",
				l, c, $sampled(samples[IDX +: WORD_BITS]), DATA_WORD));
		end
	end

	assert property (@(posedge CLK20) disable iff (SYS_RST)
		(check_mode == MODE_TRAIN) |-> align_good)
	else report_error("align_good low while training words arrive");

	assert property (@(posedge CLK20) disable iff (SYS_RST)
		(check_mode == MODE_DATA) |-> !align_good)
	else report_error("align_good high while data words arrive");

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic pick_offsets();
		for (int l = 0; l < NUM_LANES; l++) begin
			offsets[l*4 +: 4] <= 4'($urandom % WORD_BITS);
		end
	endtask

	task automatic check_idle_outputs();
		assert (aligned === 1'b0 && restart === '0 && sample_valid === '0
			&& align_good === 1'b0)
		else report_error($sformatf("outputs not idle, aligned %b restart %b valid %b good %b",
			aligned, restart, sample_valid, align_good));
	endtask

	task automatic check_restart_count(input int expected);
		for (int l = 0; l < NUM_LANES; l++) begin
			assert (restart_cnt[l] == expected)
			else report_error($sformatf("lane %0d restart pulsed %0d times, expected %0d",
				l, restart_cnt[l], expected));
		end
	endtask

	task automatic wait_aligned(input logic level);
		int cycles;
		cycles = 0;
		while (aligned !== level && cycles < ALIGN_LIMIT) begin
			@(negedge CLK20);
			cycles++;
		end
		if (aligned !== level) begin
			error_count++;
			timed_out = 1'b1;
			$display("Timeout: aligned did not reach %0b within %0d cycles", level, ALIGN_LIMIT);
		end
	endtask

	// Returns once every lane has shown n valid strobes
	task automatic wait_words(input int n);
		int seen [NUM_LANES];
		int cycles;
		bit done;
		cycles = 0;
		done   = 1'b0;
		foreach (seen[l]) begin
			seen[l] = 0;
		end
		while (!done && cycles < WORD_LIMIT * n) begin
			@(negedge CLK20);
			cycles++;
			done = 1'b1;
			for (int l = 0; l < NUM_LANES; l++) begin
				if (sample_valid[l]) begin
					seen[l]++;
				end
				if (seen[l] < n) begin
					done = 1'b0;
				end
			end
		end
		if (!done) begin
			error_count++;
			timed_out = 1'b1;
			$display("Timeout: not every lane delivered %0d words in time", n);
		end
	endtask

	task automatic close_test(input string name, input int errors_before);
		tests_run++;
		if (error_count == errors_before) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: FAILED, %0d errors", name, error_count - errors_before);
		end
	endtask

	//////////////////////////////////////////////////
	// Sequence
	//////////////////////////////////////////////////

	initial begin
		int errs;
		void'($urandom(64));
		error_count  = 0;
		tests_run    = 0;
		tests_failed = 0;
		timed_out    = 1'b0;
		SYS_RST    <= 1'b1;
		resync     <= 1'b0;
		send_data  <= 1'b0;
		check_mode <= MODE_IDLE;
		pick_offsets();

		errs = error_count;
		for (int i = 0; i < 16; i++) begin
			@(negedge CLK20);
			check_idle_outputs();
		end
		SYS_RST <= 1'b0;
		@(negedge CLK20);
		check_idle_outputs();
		close_test("Check 1 reset state", errs);

		if (!timed_out) begin
			errs = error_count;
			wait_aligned(1'b1);
			// Last restart pulse is counted on the next rising edge
			@(negedge CLK20);
			check_restart_count(1);
			close_test("Check 2 first alignment", errs);
		end

		if (!timed_out) begin
			errs = error_count;
			check_mode <= MODE_TRAIN;
			wait_words(4);
			check_mode <= MODE_IDLE;
			close_test("Check 3 training words", errs);
		end

		if (!timed_out) begin
			errs = error_count;
			send_data <= 1'b1;
			// First word after the switch may mix both streams
			wait_words(2);
			check_mode <= MODE_DATA;
			wait_words(4);
			check_mode <= MODE_IDLE;
			close_test("Check 4 data words", errs);
		end

		if (!timed_out) begin
			errs = error_count;
			resync <= 1'b1;
			@(negedge CLK20);
			resync <= 1'b0;
			wait_aligned(1'b0);
			pick_offsets();
			send_data <= 1'b0;
			wait_aligned(1'b1);
			@(negedge CLK20);
			check_restart_count(2);
			check_mode <= MODE_TRAIN;
			wait_words(4);
			check_mode <= MODE_IDLE;
			close_test("Check 5 resync and realignment", errs);
		end

		$display("Checks run %0d, failing %0d, errors %0d", tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- adc_deser.f
rtl/adc_format_pkg.sv
rtl/align_pkg.sv
rtl/lane_status_if.sv
rtl/resync_ctrl.sv
rtl/channel_deser.sv
rtl/lane_align_fsm.sv
rtl/adc_lane.sv
rtl/daq_collector.sv
rtl/adc_deser_top.sv
testbench/adc_serial_model.sv
testbench/tb_adc_deser.sv

//--- Bender.yml
package:
  name: adc_deser

sources:
  - rtl/adc_format_pkg.sv
  - rtl/align_pkg.sv
  - rtl/lane_status_if.sv
  - rtl/resync_ctrl.sv
  - rtl/channel_deser.sv
  - rtl/lane_align_fsm.sv
  - rtl/adc_lane.sv
  - rtl/daq_collector.sv
  - rtl/adc_deser_top.sv
  - target: test
    files:
      - testbench/adc_serial_model.sv
      - testbench/tb_adc_deser.sv
